// ==== soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// on-chip ram window, 4 KiB
`define RAM_BASE               32'h0000_2000
`define RAM_SIZE               32'h0000_1000

// keyboard character register
`define KEY_ADDR               32'h1000_0100

// clint style timer registers
`define MTIME_ADDR             32'h0200_bff8
`define MTIMECMP_ADDR          32'h0200_4000
// far in the future so no timer irq right after reset
`define MTIMECMP_RESET         32'h8000_0000

// plic map
`define PLIC_BASE              32'h0c00_0000
// priorities sit at base + 4 * id
`define PLIC_PENDING_OFF       32'h0000_1000
`define PLIC_ENABLE_OFF        32'h0000_2000
`define PLIC_ENABLE_CTX_STRIDE 32'h0000_0080
`define PLIC_THRESHOLD_OFF     32'h0020_0000
`define PLIC_CLAIM_OFF         32'h0020_0004
// threshold and claim step per context
`define PLIC_CTX_STRIDE        32'h0000_1000

// sources 0 to 5, id 0 means none
`define PLIC_SOURCES           32'd6
`define UART_IRQ_ID            32'd1

`endif

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // native data width of the core
    typedef logic [63:0] bus_word_t;

    // load size and sign, bit 2 set for the unsigned loads
    // stores use the lb to ld codes as sb, sh, sw, sd
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_e;

    // request from the core, enables are one-cycle pulses
    typedef struct packed {
        bus_word_t address;
        bus_word_t write_data;
        logic      read_enable;
        logic      write_enable;
        ls_type_e  ls_type;
    } bus_req_t;

    // one-hot target flags from the address decoder
    typedef struct packed {
        logic       ram;
        logic       key;
        logic       mtime;
        logic       mtimecmp;
        logic       plic_priority;
        logic       plic_pending;
        logic       plic_enable;
        logic       plic_threshold;
        logic       plic_claim;
        logic       unmapped;
        // plic context, 0 machine and 1 supervisor
        logic       ctx;
        // priority register number
        logic [2:0] plic_index;
    } target_sel_t;

    // strobes to the targets
    typedef struct packed {
        logic rd;
        logic wr;
        // upper half of a double word
        logic second;
    } access_t;

endpackage

`default_nettype wire

// ==== bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module bus_decoder (
    input  soc_pkg::bus_req_t    req,
    output soc_pkg::target_sel_t sel
);
    import soc_pkg::*;

    localparam logic [63:0] RAM_LO   = 64'(`RAM_BASE);
    localparam logic [63:0] RAM_HI   = 64'(`RAM_BASE) + 64'(`RAM_SIZE);
    localparam logic [63:0] PLIC_LO  = 64'(`PLIC_BASE);
    localparam logic [63:0] PRIO_HI  = 64'(`PLIC_BASE) + 64'(4 * `PLIC_SOURCES);
    localparam logic [63:0] PENDING  = 64'(`PLIC_BASE) + 64'(`PLIC_PENDING_OFF);
    localparam logic [63:0] ENABLE0  = 64'(`PLIC_BASE) + 64'(`PLIC_ENABLE_OFF);
    localparam logic [63:0] ENABLE1  = ENABLE0 + 64'(`PLIC_ENABLE_CTX_STRIDE);
    localparam logic [63:0] THRESH0  = 64'(`PLIC_BASE) + 64'(`PLIC_THRESHOLD_OFF);
    localparam logic [63:0] THRESH1  = THRESH0 + 64'(`PLIC_CTX_STRIDE);
    localparam logic [63:0] CLAIM0   = 64'(`PLIC_BASE) + 64'(`PLIC_CLAIM_OFF);
    localparam logic [63:0] CLAIM1   = CLAIM0 + 64'(`PLIC_CTX_STRIDE);

    logic [63:0] addr;
    logic [63:0] plic_off;
    logic [9:0]  flags;

    assign addr     = req.address;
    assign plic_off = addr - PLIC_LO;

    always_comb begin
        sel                = '0;
        sel.ram            = (addr >= RAM_LO) && (addr < RAM_HI);
        sel.key            = addr == 64'(`KEY_ADDR);
        sel.mtime          = addr == 64'(`MTIME_ADDR);
        sel.mtimecmp       = addr == 64'(`MTIMECMP_ADDR);
        // one priority word per source
        sel.plic_priority  = (addr >= PLIC_LO) && (addr < PRIO_HI);
        sel.plic_pending   = addr == PENDING;
        sel.plic_enable    = (addr == ENABLE0) || (addr == ENABLE1);
        sel.plic_threshold = (addr == THRESH0) || (addr == THRESH1);
        sel.plic_claim     = (addr == CLAIM0) || (addr == CLAIM1);
        // context 1 copies
        sel.ctx            = (addr == ENABLE1) || (addr == THRESH1) || (addr == CLAIM1);
        // offset / 4
        sel.plic_index     = plic_off[4:2];
        sel.unmapped       = !(sel.ram || sel.key || sel.mtime || sel.mtimecmp ||
                               sel.plic_priority || sel.plic_pending || sel.plic_enable ||
                               sel.plic_threshold || sel.plic_claim);
    end

    assign flags = sel[13:4];

    // regions of the map must not overlap
    always_comb begin
        if (!$isunknown(addr)) begin
            assert ($onehot(flags))
            else $error("bus_decoder: overlapping regions at %h", addr);
        end
    end

endmodule

`default_nettype wire

// ==== bus_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module bus_sequencer (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_pkg::bus_req_t    req,
    input  soc_pkg::target_sel_t sel,
    input  soc_pkg::bus_word_t   ram_rdata,
    input  soc_pkg::bus_word_t   plic_rdata,
    input  soc_pkg::bus_word_t   mtime,
    input  logic [7:0]           key_ascii,
    output soc_pkg::access_t     access,
    output soc_pkg::bus_word_t   read_data,
    output logic                 read_done,
    output logic                 write_done,
    output soc_pkg::bus_word_t   mtimecmp
);
    import soc_pkg::*;

    logic      rd_q;
    logic      wr_q;
    // low or high word of a ram ld/sd
    logic      step;
    logic      two_step;
    logic      plic_hit;
    logic      from_ram;
    logic      from_plic;
    bus_word_t local_rdata;

    assign two_step = sel.ram && (req.ls_type == ld);
    assign plic_hit = sel.plic_priority || sel.plic_pending || sel.plic_enable ||
                      sel.plic_threshold || sel.plic_claim;

    // strobes live for one cycle after the enable
    assign access = '{rd: rd_q, wr: wr_q, second: step};

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_q       <= 1'b0;
            wr_q       <= 1'b0;
            step       <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            from_ram   <= 1'b0;
            from_plic  <= 1'b0;
            mtimecmp   <= 64'(`MTIMECMP_RESET);
        end else begin
            rd_q <= req.read_enable;
            wr_q <= req.write_enable;
            // done falls on the edge that sees the enable
            if (req.read_enable) begin
                read_done <= 1'b0;
            end
            if (req.write_enable) begin
                write_done <= 1'b0;
            end
            if (rd_q || wr_q) begin
                if (two_step && !step) begin
                    // one more strobe for the upper word
                    step <= 1'b1;
                    rd_q <= rd_q;
                    wr_q <= wr_q;
                end else begin
                    step       <= 1'b0;
                    read_done  <= 1'b1;
                    write_done <= 1'b1;
                end
            end
            // remember where the answer comes from
            if (rd_q) begin
                from_ram  <= sel.ram;
                from_plic <= plic_hit;
            end
            if (wr_q && sel.mtimecmp) begin
                mtimecmp <= req.write_data;
            end
        end
    end

    // local sources sampled at the strobe edge
    always_ff @(posedge CLOCK_50) begin
        if (rd_q) begin
            if (sel.mtime) begin
                local_rdata <= mtime;
            end else if (sel.mtimecmp) begin
                local_rdata <= mtimecmp;
            end else if (sel.key) begin
                local_rdata <= {56'd0, key_ascii};
            end else begin
                // unmapped reads give zero
                local_rdata <= '0;
            end
        end
    end

    // ram and plic hold their own read registers
    assign read_data = from_ram  ? ram_rdata  :
                       from_plic ? plic_rdata : local_rdata;

    // the core never reads and writes at once
    a_single_enable : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(req.read_enable && req.write_enable))
    else $error("bus_sequencer: read and write enable together");

    // a new request only after the last one completed
    a_idle_on_enable : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.read_enable || req.write_enable) |-> (read_done && write_done))
    else $error("bus_sequencer: enable while busy");

endmodule

`default_nettype wire

// ==== ram_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module ram_port (
    input  logic                 CLOCK_50,
    input  soc_pkg::bus_req_t    req,
    input  soc_pkg::target_sel_t sel,
    input  soc_pkg::access_t     access,
    output soc_pkg::bus_word_t   rdata
);
    import soc_pkg::*;

    localparam int WORDS = `RAM_SIZE / 4;
    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [31:0]      offset;
    logic [1:0]       lane;
    logic [IDX_W-1:0] idx;
    logic [31:0]      word;
    logic [31:0]      shifted;
    logic [3:0]       be;
    logic [31:0]      wword;

    assign offset = req.address[31:0] - `RAM_BASE;
    assign lane   = offset[1:0];
    // upper half of ld/sd goes to the next word
    assign idx    = offset[IDX_W+1:2] + IDX_W'(access.second);
    assign word   = mem[idx];
    // addressed byte moved down to bit 0
    assign shifted = word >> {lane, 3'b000};

    // byte enables and replicated store data
    always_comb begin
        be    = 4'b0000;
        wword = req.write_data[31:0];
        case (req.ls_type)
            lb: begin
                be    = 4'b0001 << lane;
                wword = {4{req.write_data[7:0]}};
            end
            lh: begin
                be    = lane[1] ? 4'b1100 : 4'b0011;
                wword = {2{req.write_data[15:0]}};
            end
            lw: begin
                be = 4'b1111;
            end
            ld: begin
                be    = 4'b1111;
                wword = access.second ? req.write_data[63:32] : req.write_data[31:0];
            end
            default: begin
                be = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (access.wr && sel.ram) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= wword[8*b +: 8];
                end
            end
        end
    end

    // extend to 64 bits by load type
    always_ff @(posedge CLOCK_50) begin
        if (access.rd && sel.ram) begin
            case (req.ls_type)
                lb:  rdata <= {{56{shifted[7]}}, shifted[7:0]};
                lbu: rdata <= {56'd0, shifted[7:0]};
                lh:  rdata <= {{48{shifted[15]}}, shifted[15:0]};
                lhu: rdata <= {48'd0, shifted[15:0]};
                lw:  rdata <= {{32{shifted[31]}}, shifted};
                lwu: rdata <= {32'd0, shifted};
                ld: begin
                    // low word first, high word on the second strobe
                    if (access.second) begin
                        rdata[63:32] <= word;
                    end else begin
                        rdata <= {32'd0, word};
                    end
                end
                default: rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== plic.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module plic (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_pkg::bus_req_t    req,
    input  soc_pkg::target_sel_t sel,
    input  soc_pkg::access_t     access,
    input  logic                 uart_irq,
    output soc_pkg::bus_word_t   rdata,
    output logic                 meip_interrupt,
    output logic                 msip_interrupt
);
    import soc_pkg::*;

    localparam int SRC    = `PLIC_SOURCES;
    localparam int IRQ_ID = `UART_IRQ_ID;

    logic [2:0]  prio [SRC];
    logic [31:0] pending;
    logic [31:0] enable [2];
    logic [2:0]  threshold [2];
    // id a context would get on a claim read
    logic [2:0]  claim_id [2];
    logic        irq_q;
    logic        irq_rise;

    assign irq_rise = uart_irq && !irq_q;

    // only source 1 is wired
    // priority and threshold take no part
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = (pending[IRQ_ID] && enable[c][IRQ_ID]) ? 3'(IRQ_ID) : 3'd0;
        end
    end

    // context 0 to meip and context 1 to msip
    assign meip_interrupt = claim_id[0] != 3'd0;
    assign msip_interrupt = claim_id[1] != 3'd0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < SRC; i++) begin
                prio[i] <= 3'd0;
            end
            pending      <= '0;
            enable[0]    <= '0;
            enable[1]    <= '0;
            threshold[0] <= 3'd0;
            threshold[1] <= 3'd0;
            irq_q        <= 1'b0;
        end else begin
            irq_q <= uart_irq;
            if (access.wr) begin
                if (sel.plic_priority) begin
                    prio[sel.plic_index] <= req.write_data[2:0];
                end
                if (sel.plic_enable) begin
                    enable[sel.ctx] <= req.write_data[31:0];
                end
                if (sel.plic_threshold) begin
                    threshold[sel.ctx] <= req.write_data[2:0];
                end
                // complete names the id to retire
                if (sel.plic_claim) begin
                    pending[req.write_data[4:0]] <= 1'b0;
                end
            end
            // claim read retires the id it returns
            if (access.rd && sel.plic_claim && (claim_id[sel.ctx] != 3'd0)) begin
                pending[5'(claim_id[sel.ctx])] <= 1'b0;
            end
            // a fresh edge wins over a clear in the same cycle
            if (irq_rise) begin
                pending[IRQ_ID] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (access.rd) begin
            if (sel.plic_priority) begin
                rdata <= {61'd0, prio[sel.plic_index]};
            end else if (sel.plic_pending) begin
                rdata <= {32'd0, pending};
            end else if (sel.plic_enable) begin
                rdata <= {32'd0, enable[sel.ctx]};
            end else if (sel.plic_threshold) begin
                rdata <= {61'd0, threshold[sel.ctx]};
            end else if (sel.plic_claim) begin
                rdata <= {61'd0, claim_id[sel.ctx]};
            end
        end
    end

    // claimed id always names a real source
    a_claim_range : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (access.rd && sel.plic_claim) |=> (rdata < 64'(SRC)))
    else $error("plic: claimed id out of range");

endmodule

`default_nettype wire

// ==== soc_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  soc_pkg::bus_req_t  req,
    input  soc_pkg::bus_word_t mtime,
    input  logic [7:0]         key_ascii,
    input  logic               uart_irq,
    output soc_pkg::bus_word_t read_data,
    output logic               read_done,
    output logic               write_done,
    output soc_pkg::bus_word_t mtimecmp,
    output logic               meip_interrupt,
    output logic               msip_interrupt
);
    import soc_pkg::*;

    target_sel_t sel;
    access_t     access;
    bus_word_t   ram_rdata;
    bus_word_t   plic_rdata;

    // address to target, combinational
    bus_decoder u_decoder (
        .req (req),
        .sel (sel)
    );

    // handshake, strobes and read mux
    bus_sequencer u_sequencer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .sel        (sel),
        .ram_rdata  (ram_rdata),
        .plic_rdata (plic_rdata),
        .mtime      (mtime),
        .key_ascii  (key_ascii),
        .access     (access),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .mtimecmp   (mtimecmp)
    );

    ram_port u_ram (
        .CLOCK_50 (CLOCK_50),
        .req      (req),
        .sel      (sel),
        .access   (access),
        .rdata    (ram_rdata)
    );

    plic u_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req            (req),
        .sel            (sel),
        .access         (access),
        .uart_irq       (uart_irq),
        .rdata          (plic_rdata),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);
    // 10 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #5;
            CLOCK_50 = ~CLOCK_50;
        end
    end

    // active low reset over the first 10 cycles
    initial begin
        KEY0 <= 1'b0;
        repeat (10) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module tb_soc_bus;
    import soc_pkg::*;

    // wait loop bounds in cycles
    localparam int WAIT_LIMIT  = 20;
    localparam int RESET_LIMIT = 50;

    // address map as seen from the core
    localparam bus_word_t RAM_LO  = 64'(`RAM_BASE);
    localparam bus_word_t RAM_HI  = 64'(`RAM_BASE) + 64'(`RAM_SIZE);
    localparam bus_word_t PENDING = 64'(`PLIC_BASE) + 64'(`PLIC_PENDING_OFF);
    localparam bus_word_t ENABLE0 = 64'(`PLIC_BASE) + 64'(`PLIC_ENABLE_OFF);
    localparam bus_word_t ENABLE1 = ENABLE0 + 64'(`PLIC_ENABLE_CTX_STRIDE);
    localparam bus_word_t THRESH0 = 64'(`PLIC_BASE) + 64'(`PLIC_THRESHOLD_OFF);
    localparam bus_word_t THRESH1 = THRESH0 + 64'(`PLIC_CTX_STRIDE);
    localparam bus_word_t CLAIM0  = 64'(`PLIC_BASE) + 64'(`PLIC_CLAIM_OFF);
    localparam bus_word_t CLAIM1  = CLAIM0 + 64'(`PLIC_CTX_STRIDE);
    localparam bus_word_t IRQ_BIT = 64'(1) << `UART_IRQ_ID;

    // one bus access with its expected answer
    typedef struct packed {
        logic      wr;
        bus_word_t addr;
        ls_type_e  ls;
        bus_word_t wdata;
        bus_word_t exp_data;
    } row_t;

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    req;
    bus_word_t   mtime;
    logic [7:0]  key_ascii;
    logic        uart_irq;
    bus_word_t   read_data;
    logic        read_done;
    logic        write_done;
    bus_word_t   mtimecmp;
    logic        meip_interrupt;
    logic        msip_interrupt;

    row_t        rows [$];
    // little endian byte image of the ram
    logic [7:0]  ram_model [`RAM_SIZE];
    bus_word_t   cmp_model;
    bus_word_t   enable_model [2];
    logic [31:0] rng_state = 32'hfb94_4c6e;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    tb_clock_gen u_clock (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_bus_top u_dut (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req            (req),
        .mtime          (mtime),
        .key_ascii      (key_ascii),
        .uart_irq       (uart_irq),
        .read_data      (read_data),
        .read_done      (read_done),
        .write_done     (write_done),
        .mtimecmp       (mtimecmp),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_word_t random_word();
        return {next_random(), next_random()};
    endfunction

    function automatic int access_bytes(ls_type_e ls);
        case (ls)
            lb, lbu: return 1;
            lh, lhu: return 2;
            lw, lwu: return 4;
            default: return 8;
        endcase
    endfunction

    // ld and sd to ram take two steps and all else one
    function automatic int done_low_cycles(bus_word_t addr, ls_type_e ls);
        if (addr >= RAM_LO && addr < RAM_HI && ls == ld) begin
            return 2;
        end
        return 1;
    endfunction

    function automatic void record_store(bus_word_t addr, ls_type_e ls, bus_word_t data);
        int off;
        off = int'(addr - RAM_LO);
        for (int i = 0; i < access_bytes(ls); i++) begin
            ram_model[off + i] = data[8*i +: 8];
        end
    endfunction

    function automatic bus_word_t predict_load(bus_word_t addr, ls_type_e ls);
        int        off;
        int        n;
        bus_word_t v;
        off = int'(addr - RAM_LO);
        n   = access_bytes(ls);
        v   = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ram_model[off + i];
        end
        // signed loads copy the top bit upwards
        if ((ls == lb || ls == lh || ls == lw) && v[8*n-1]) begin
            for (int i = 8*n; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    function automatic void push_row(logic wr, bus_word_t addr, ls_type_e ls,
                                     bus_word_t wdata, bus_word_t exp_data);
        rows.push_back('{wr, addr, ls, wdata, exp_data});
    endfunction

    function automatic void build_table();
        bus_word_t base;
        bus_word_t d;
        ls_type_e  ls;
        int        off;
        int        n;
        // one store width per 8 byte area and then every load over it
        for (int w = 0; w < 4; w++) begin
            base = RAM_LO + 64'(next_random() & 32'h0000_0ff8);
            // ram starts unknown so both words are filled first
            for (int k = 0; k < 8; k += 4) begin
                d = random_word();
                push_row(1'b1, base + 64'(k), lw, d, '0);
                record_store(base + 64'(k), lw, d);
            end
            ls  = ls_type_e'(3'(w));
            n   = access_bytes(ls);
            off = int'(next_random() % 8) & ~(n - 1);
            d   = random_word();
            push_row(1'b1, base + 64'(off), ls, d, '0);
            record_store(base + 64'(off), ls, d);
            for (int t = 0; t < 7; t++) begin
                ls = ls_type_e'(3'(t));
                for (int o = 0; o < 8; o += access_bytes(ls)) begin
                    push_row(1'b0, base + 64'(o), ls, '0, predict_load(base + 64'(o), ls));
                end
            end
        end

        // timer and keyboard
        cmp_model = random_word();
        push_row(1'b1, 64'(`MTIMECMP_ADDR), ld, cmp_model, '0);
        push_row(1'b0, 64'(`MTIMECMP_ADDR), ld, '0, cmp_model);
        push_row(1'b0, 64'(`MTIME_ADDR), ld, '0, mtime);
        push_row(1'b0, 64'(`KEY_ADDR), lbu, '0, {56'd0, key_ascii});

        // priorities keep three bits
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            d = random_word();
            push_row(1'b1, 64'(`PLIC_BASE) + 64'(4 * i), lw, d, '0);
            push_row(1'b0, 64'(`PLIC_BASE) + 64'(4 * i), lw, '0, d & 64'h7);
        end
        for (int c = 0; c < 2; c++) begin
            d = random_word();
            enable_model[c] = {32'd0, d[31:0]};
            push_row(1'b1, c ? ENABLE1 : ENABLE0, lw, d, '0);
            push_row(1'b0, c ? ENABLE1 : ENABLE0, lw, '0, enable_model[c]);
            d = random_word();
            push_row(1'b1, c ? THRESH1 : THRESH0, lw, d, '0);
            push_row(1'b0, c ? THRESH1 : THRESH0, lw, '0, d & 64'h7);
        end
        // no irq edge yet
        push_row(1'b0, PENDING, lw, '0, '0);

        // holes in the map read zero
        push_row(1'b0, 64'h0, ld, '0, '0);
        push_row(1'b0, RAM_LO - 64'd4, lw, '0, '0);
        push_row(1'b0, 64'h4000_0000, lw, '0, '0);
        // first ram word shares its index bits with both stray write addresses
        d = random_word();
        push_row(1'b1, RAM_LO, lw, d, '0);
        record_store(RAM_LO, lw, d);
        // sd just past the ram takes one step
        push_row(1'b1, RAM_HI, ld, random_word(), '0);
        push_row(1'b1, 64'h3000_0000, lw, random_word(), '0);
        // earlier state survives the stray writes
        push_row(1'b0, 64'(`MTIMECMP_ADDR), ld, '0, cmp_model);
        push_row(1'b0, ENABLE0, lw, '0, enable_model[0]);
        push_row(1'b0, RAM_LO, lw, '0, predict_load(RAM_LO, lw));
        push_row(1'b0, base, ld, '0, predict_load(base, ld));
    endfunction

    task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // enable for one edge and count the cycles done stays low
    task automatic run_access(input logic wr, input bus_word_t addr, input ls_type_e ls,
                              input bus_word_t wdata, output bus_word_t data,
                              output int low);
        @(posedge CLOCK_50);
        req.address      <= addr;
        req.write_data   <= wdata;
        req.ls_type      <= ls;
        req.read_enable  <= !wr;
        req.write_enable <= wr;
        @(posedge CLOCK_50);
        req.read_enable  <= 1'b0;
        req.write_enable <= 1'b0;
        low = 0;
        @(negedge CLOCK_50);
        while (!(read_done && write_done) && low <= WAIT_LIMIT) begin
            low++;
            @(negedge CLOCK_50);
        end
        if (!(read_done && write_done)) begin
            timeouts++;
            $display("timeout: bus access at %h never completed", addr);
        end
        data = read_data;
    endtask

    task automatic read_reg(input bus_word_t addr, output bus_word_t data);
        int low;
        run_access(1'b0, addr, lw, '0, data, low);
        check_count(low, 1, "done low cycles, register read");
    endtask

    task automatic write_reg(input bus_word_t addr, input bus_word_t data);
        int        low;
        bus_word_t unused;
        run_access(1'b1, addr, lw, data, unused, low);
        check_count(low, 1, "done low cycles, register write");
    endtask

    // short high pulse that the plic catches on its rising edge
    task automatic pulse_irq();
        @(posedge CLOCK_50);
        uart_irq <= 1'b1;
        repeat (2) @(posedge CLOCK_50);
        uart_irq <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    initial begin
        bus_word_t got;
        int        low;
        int        cycles;
        req       <= '0;
        mtime     <= random_word();
        // top bit set so a sign extension would show
        key_ascii <= 8'(next_random()) | 8'h80;
        uart_irq  <= 1'b0;

        cycles = 0;
        @(negedge CLOCK_50);
        while (KEY0 !== 1'b1 && cycles <= RESET_LIMIT) begin
            cycles++;
            @(negedge CLOCK_50);
        end
        if (KEY0 !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        // state right after reset
        check_bit(read_done, 1'b1, "read_done after reset");
        check_bit(write_done, 1'b1, "write_done after reset");
        check_bit(meip_interrupt, 1'b0, "meip after reset");
        check_bit(msip_interrupt, 1'b0, "msip after reset");
        check_word(mtimecmp, 64'(`MTIMECMP_RESET), "mtimecmp port after reset");
        read_reg(64'(`MTIMECMP_ADDR), got);
        check_word(got, 64'(`MTIMECMP_RESET), "mtimecmp read after reset");

        build_table();
        foreach (rows[i]) begin
            run_access(rows[i].wr, rows[i].addr, rows[i].ls, rows[i].wdata, got, low);
            check_count(low, done_low_cycles(rows[i].addr, rows[i].ls),
                        $sformatf("done low cycles, row %0d", i));
            if (!rows[i].wr) begin
                check_word(got, rows[i].exp_data,
                           $sformatf("read data, row %0d at %h", i, rows[i].addr));
            end
        end
        check_word(mtimecmp, cmp_model, "mtimecmp port after write");

        // interrupt path for source 1
        write_reg(ENABLE0, '0);
        write_reg(ENABLE1, '0);
        pulse_irq();
        read_reg(PENDING, got);
        check_word(got, IRQ_BIT, "pending after irq edge");
        check_bit(meip_interrupt, 1'b0, "meip while disabled");
        check_bit(msip_interrupt, 1'b0, "msip while disabled");
        write_reg(ENABLE0, IRQ_BIT);
        check_bit(meip_interrupt, 1'b1, "meip with context 0 enabled");
        check_bit(msip_interrupt, 1'b0, "msip with context 0 enabled");
        write_reg(ENABLE1, IRQ_BIT);
        check_bit(msip_interrupt, 1'b1, "msip with context 1 enabled");

        // claim retires the pending bit for both contexts
        read_reg(CLAIM0, got);
        check_word(got, 64'(`UART_IRQ_ID), "claim id, context 0");
        check_bit(meip_interrupt, 1'b0, "meip after claim");
        check_bit(msip_interrupt, 1'b0, "msip after claim");
        read_reg(PENDING, got);
        check_word(got, '0, "pending after claim");
        read_reg(CLAIM1, got);
        check_word(got, '0, "claim id with nothing pending");

        // complete by write clears a new edge
        pulse_irq();
        check_bit(meip_interrupt, 1'b1, "meip after second edge");
        check_bit(msip_interrupt, 1'b1, "msip after second edge");
        write_reg(CLAIM1, 64'(`UART_IRQ_ID));
        check_bit(meip_interrupt, 1'b0, "meip after complete");
        check_bit(msip_interrupt, 1'b0, "msip after complete");
        read_reg(PENDING, got);
        check_word(got, '0, "pending after complete");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
soc_pkg.sv
bus_decoder.sv
bus_sequencer.sv
ram_port.sv
plic.sv
soc_bus_top.sv
tb_clock_gen.sv
tb_soc_bus.sv

// ==== Makefile ====
TOP := tb_soc_bus

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
